//--- hdl/rx_pkg.sv
package rx_pkg;

    ////////////////////////////////
    // receive data shape
    ////////////////////////////////

    // time-interleaved lanes
    localparam int NTI = 16;

    // bits per ADC code
    localparam int NADC = 8;

    // one ADC code, two's complement
    typedef logic signed [NADC-1:0] adc_code_t;

    // one decision bit per lane
    typedef logic [NTI-1:0] lane_bits_t;

endpackage

//--- hdl/prbs_pkg.sv
package prbs_pkg;

    ////////////////////////////////
    // PRBS pattern
    ////////////////////////////////

    // x^7 + x^6 + 1
    localparam int NPRBS      = 7;
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

    // generator state out of reset
    localparam logic [NPRBS-1:0] PRBS_SEED = '1;

    ////////////////////////////////
    // counters and readout
    ////////////////////////////////

    localparam int NCOUNT = 64;
    localparam int NWORD  = 32;

    typedef logic [NCOUNT-1:0] count_t;
    typedef logic [NWORD-1:0]  word_t;

    // checker source select
    typedef logic src_sel_t;
    localparam src_sel_t SRC_ADC  = 1'b0;
    localparam src_sel_t SRC_BIST = 1'b1;

    // readout checker select
    typedef logic chk_sel_t;
    localparam chk_sel_t CHK_MAIN = 1'b0;
    localparam chk_sel_t CHK_TRIG = 1'b1;

endpackage

//--- hdl/adc_slicer.sv
`timescale 1ns/1ps

module adc_slicer import rx_pkg::*; (
    input  logic       clk_adc,
    input  logic       cdr_rstb,
    input  adc_code_t  adc_codes_i [NTI-1:0],
    input  adc_code_t  thresh_i,
    output lane_bits_t bits_o
);

    lane_bits_t decision;

    // signed compare per lane
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            decision[k] = (adc_codes_i[k] > thresh_i);
        end
    end

    // one cycle of latency, same as the BIST source
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            bits_o <= '0;
        end else begin
            bits_o <= decision;
        end
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // unknown codes from the ADC model would reach both checkers
    a_bits_known: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        !$isunknown(bits_o)
    ) else $error("slicer output unknown: %b", bits_o);

endmodule

//--- hdl/prbs_bist_gen.sv
`timescale 1ns/1ps

module prbs_bist_gen import rx_pkg::*, prbs_pkg::*; (
    input  logic       clk_adc,
    input  logic       cdr_rstb,
    input  logic       inj_err_i,
    output lane_bits_t bits_o
);

    // state[0] holds the newest bit, state[NPRBS-1] the oldest
    logic [NPRBS-1:0] prbs_state;
    logic             next_bit;
    logic             bit_r;

    // Fibonacci feedback from the two history taps
    assign next_bit = prbs_state[PRBS_TAP_A-1] ^ prbs_state[PRBS_TAP_B-1];

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            prbs_state <= PRBS_SEED;
        end else begin
            prbs_state <= {prbs_state[NPRBS-2:0], next_bit};
        end
    end

    // injected error flips only the outgoing bit
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            bit_r <= 1'b0;
        end else begin
            bit_r <= next_bit ^ inj_err_i;
        end
    end

    // same serial stream on every lane
    assign bits_o = {NTI{bit_r}};

    ////////////////////////////////
    // checks
    ////////////////////////////////

    // all zeros is the lock-up state of this LFSR
    a_state_nonzero: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        prbs_state != '0
    ) else $error("PRBS generator locked up at zero");

endmodule

//--- hdl/prbs_lane_checker.sv
`timescale 1ns/1ps

module prbs_lane_checker import rx_pkg::*, prbs_pkg::*; (
    input  logic       clk_adc,
    input  logic       cdr_rstb,
    input  logic       cke_i,
    input  src_sel_t   src_sel_i,
    input  lane_bits_t adc_bits_i,
    input  lane_bits_t bist_bits_i,
    input  lane_bits_t chan_sel_i,
    output count_t     err_count_o,
    output count_t     total_count_o
);

    localparam int NPOP  = $clog2(NTI + 1);
    localparam int NWARM = $clog2(NPRBS + 1);

    function automatic logic [NPOP-1:0] popcount(input lane_bits_t v);
        logic [NPOP-1:0] n;
        n = '0;
        for (int k = 0; k < NTI; k++) begin
            n = n + NPOP'(v[k]);
        end
        return n;
    endfunction

    logic             cke_d;
    lane_bits_t       rx_bits;
    lane_bits_t       hist [NPRBS];
    lane_bits_t       expect_bits;
    lane_bits_t       err_lanes;
    logic [NWARM-1:0] warm_cnt;
    logic             check_en;
    lane_bits_t       err_flags;
    lane_bits_t       tot_flags;

    assign rx_bits = (src_sel_i == SRC_BIST) ? bist_bits_i : adc_bits_i;

    // cke lined up with the registered sources
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            cke_d    <= 1'b0;
            warm_cnt <= '0;
        end else begin
            cke_d <= cke_i;
            if (cke_d && (warm_cnt != NWARM'(NPRBS))) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
        end
    end

    // per-lane history, hist[0] is last cycle's bit
    // follows the source every cycle, the generator never stops
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int i = 0; i < NPRBS; i++) begin
                hist[i] <= '0;
            end
        end else begin
            hist[0] <= rx_bits;
            for (int i = 1; i < NPRBS; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    assign expect_bits = hist[PRBS_TAP_A-1] ^ hist[PRBS_TAP_B-1];
    assign err_lanes   = rx_bits ^ expect_bits;
    assign check_en    = cke_d && (warm_cnt == NWARM'(NPRBS));

    ////////////////////////////////
    // check stage and counters
    ////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_flags <= '0;
            tot_flags <= '0;
        end else begin
            err_flags <= check_en ? (err_lanes & chan_sel_i) : '0;
            tot_flags <= check_en ? chan_sel_i : '0;
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else begin
            err_count_o   <= err_count_o + count_t'(popcount(err_flags));
            total_count_o <= total_count_o + count_t'(popcount(tot_flags));
        end
    end

    // masked errors are a subset of masked lanes
    a_err_le_total: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        err_count_o <= total_count_o
    ) else $error("error count above total count");

    a_counts_monotonic: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        (err_count_o >= $past(err_count_o)) && (total_count_o >= $past(total_count_o))
    ) else $error("PRBS counter went backwards");

endmodule

//--- hdl/prbs_count_readout.sv
`timescale 1ns/1ps

module prbs_count_readout import rx_pkg::*, prbs_pkg::*; (
    input  logic     clk_adc,
    input  logic     cdr_rstb,
    input  logic     snap_i,
    input  chk_sel_t sel_count_i,
    input  count_t   main_err_i,
    input  count_t   main_total_i,
    input  count_t   trig_err_i,
    input  count_t   trig_total_i,
    output word_t    err_upper_o,
    output word_t    err_lower_o,
    output word_t    total_upper_o,
    output word_t    total_lower_o
);

    count_t err_snap;
    count_t total_snap;

    // both counts taken on the same edge so the word pairs stay coherent
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_snap   <= '0;
            total_snap <= '0;
        end else if (snap_i) begin
            if (sel_count_i == CHK_TRIG) begin
                err_snap   <= trig_err_i;
                total_snap <= trig_total_i;
            end else begin
                err_snap   <= main_err_i;
                total_snap <= main_total_i;
            end
        end
    end

    // 64-bit counts as upper and lower words
    assign err_upper_o   = err_snap[NCOUNT-1:NWORD];
    assign err_lower_o   = err_snap[NWORD-1:0];
    assign total_upper_o = total_snap[NCOUNT-1:NWORD];
    assign total_lower_o = total_snap[NWORD-1:0];

    a_snap_consistent: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        err_snap <= total_snap
    ) else $error("snapshot error count above snapshot total");

endmodule

//--- hdl/prbs_test_core.sv
`timescale 1ns/1ps

module prbs_test_core import rx_pkg::*, prbs_pkg::*; (
    input  logic       clk_adc,
    input  logic       cdr_rstb,
    input  adc_code_t  adc_codes_i [NTI-1:0],
    input  adc_code_t  thresh_i,
    input  logic       inj_err_i,
    input  logic       cke_i,
    input  src_sel_t   main_src_i,
    input  src_sel_t   trig_src_i,
    input  lane_bits_t chan_sel_i,
    input  chk_sel_t   sel_count_i,
    input  logic       snap_i,
    output word_t      err_upper_o,
    output word_t      err_lower_o,
    output word_t      total_upper_o,
    output word_t      total_lower_o
);

    lane_bits_t adc_bits;
    lane_bits_t bist_bits;
    count_t     main_err;
    count_t     main_total;
    count_t     trig_err;
    count_t     trig_total;

    ////////////////////////////////
    // bit sources
    ////////////////////////////////

    adc_slicer slicer0 (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_codes_i (adc_codes_i),
        .thresh_i    (thresh_i),
        .bits_o      (adc_bits)
    );

    prbs_bist_gen bist0 (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .inj_err_i (inj_err_i),
        .bits_o    (bist_bits)
    );

    ////////////////////////////////
    // checkers
    ////////////////////////////////

    // main and trigger checkers share cke and lane mask
    prbs_lane_checker chk_main (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .cke_i         (cke_i),
        .src_sel_i     (main_src_i),
        .adc_bits_i    (adc_bits),
        .bist_bits_i   (bist_bits),
        .chan_sel_i    (chan_sel_i),
        .err_count_o   (main_err),
        .total_count_o (main_total)
    );

    prbs_lane_checker chk_trig (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .cke_i         (cke_i),
        .src_sel_i     (trig_src_i),
        .adc_bits_i    (adc_bits),
        .bist_bits_i   (bist_bits),
        .chan_sel_i    (chan_sel_i),
        .err_count_o   (trig_err),
        .total_count_o (trig_total)
    );

    prbs_count_readout readout0 (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .snap_i        (snap_i),
        .sel_count_i   (sel_count_i),
        .main_err_i    (main_err),
        .main_total_i  (main_total),
        .trig_err_i    (trig_err),
        .trig_total_i  (trig_total),
        .err_upper_o   (err_upper_o),
        .err_lower_o   (err_lower_o),
        .total_upper_o (total_upper_o),
        .total_lower_o (total_lower_o)
    );

endmodule

//--- tb/tb_prbs_test_core.sv
`timescale 1ns/1ps

module tb_prbs_test_core import rx_pkg::*, prbs_pkg::*; ();

    localparam int    HALF_PERIOD   = 20;
    localparam int    CLK_PERIOD    = 2 * HALF_PERIOD;
    localparam int    RST_CYCLES    = 16;
    localparam int    SETTLE_CYCLES = 8;
    localparam int    IDLE_CYCLES   = 5;
    localparam int    READ_CYCLES   = 2;
    localparam int    DRIVE_DELAY   = 2;
    localparam int    MAX_INJ       = 4;
    localparam string GOLDEN_PATH   = "tb/prbs_golden.txt";

    logic       clk_adc;
    logic       cdr_rstb;
    adc_code_t  adc_codes [NTI-1:0];
    adc_code_t  thresh;
    logic       inj_err;
    logic       cke;
    src_sel_t   main_src;
    src_sel_t   trig_src;
    lane_bits_t chan_sel;
    chk_sel_t   sel_count;
    logic       snap;
    word_t      err_upper;
    word_t      err_lower;
    word_t      total_upper;
    word_t      total_lower;

    // phase records, injection offsets flattened MAX_INJ per phase
    int     ph_main_src [$];
    int     ph_trig_src [$];
    int     ph_thresh [$];
    int     ph_code [$];
    int     ph_chan [$];
    int     ph_ncyc [$];
    int     ph_ninj [$];
    int     ph_inj [$];
    int     ph_sel [$];
    longint ph_err [$];
    longint ph_total [$];

    int     error_count = 0;
    int     check_count = 0;
    longint watchdog_ns = 0;
    longint prev_err    = 0;
    longint prev_total  = 0;

    prbs_test_core dut0 (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_codes_i   (adc_codes),
        .thresh_i      (thresh),
        .inj_err_i     (inj_err),
        .cke_i         (cke),
        .main_src_i    (main_src),
        .trig_src_i    (trig_src),
        .chan_sel_i    (chan_sel),
        .sel_count_i   (sel_count),
        .snap_i        (snap),
        .err_upper_o   (err_upper),
        .err_lower_o   (err_lower),
        .total_upper_o (total_upper),
        .total_lower_o (total_lower)
    );

    initial clk_adc = 1'b0;
    always #(HALF_PERIOD) clk_adc = ~clk_adc;

    // watchdog armed once the phase lengths are known
    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    task automatic next_cycle();
        @(posedge clk_adc);
        #(DRIVE_DELAY);
    endtask

    task automatic load_golden(output logic ok);
        int     fd;
        int     n;
        string  line;
        int     ms, ts, th, cd, cs, nc, ni, i0, i1, i2, i3, sl;
        longint ee, et;
        ok = 1'b1;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN_PATH);
            ok = 1'b0;
            return;
        end
        while (ok && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %h %d %d %d %d %d %d %d %d %d",
                        ms, ts, th, cd, cs, nc, ni, i0, i1, i2, i3, sl, ee, et);
            if (n != 14 || ni < 0 || ni > MAX_INJ || nc < 0) begin
                $display("malformed golden record: %s", line);
                ok = 1'b0;
            end else begin
                ph_main_src.push_back(ms);
                ph_trig_src.push_back(ts);
                ph_thresh.push_back(th);
                ph_code.push_back(cd);
                ph_chan.push_back(cs);
                ph_ncyc.push_back(nc);
                ph_ninj.push_back(ni);
                ph_inj.push_back(i0);
                ph_inj.push_back(i1);
                ph_inj.push_back(i2);
                ph_inj.push_back(i3);
                ph_sel.push_back(sl);
                ph_err.push_back(ee);
                ph_total.push_back(et);
            end
        end
        $fclose(fd);
        if (ok && ph_ncyc.size() == 0) begin
            $display("golden file holds no phase records");
            ok = 1'b0;
        end
    endtask

    function automatic logic inject_at(input int p, input int c);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < ph_ninj[p]; i++) begin
            if (ph_inj[p*MAX_INJ + i] == c) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic check_counts(input longint exp_err, input longint exp_total);
        count_t e;
        count_t t;
        e = count_t'(exp_err);
        t = count_t'(exp_total);
        check_word("err_upper_o", e[NCOUNT-1:NWORD], err_upper);
        check_word("err_lower_o", e[NWORD-1:0], err_lower);
        check_word("total_upper_o", t[NCOUNT-1:NWORD], total_upper);
        check_word("total_lower_o", t[NWORD-1:0], total_lower);
    endtask

    task automatic run_phase(input int p);
        main_src  = src_sel_t'(ph_main_src[p]);
        trig_src  = src_sel_t'(ph_trig_src[p]);
        thresh    = adc_code_t'(ph_thresh[p]);
        chan_sel  = lane_bits_t'(ph_chan[p]);
        sel_count = chk_sel_t'(ph_sel[p]);
        for (int k = 0; k < NTI; k++) begin
            adc_codes[k] = adc_code_t'(ph_code[p]);
        end
        // let the checker history fill from the new source
        repeat (SETTLE_CYCLES) next_cycle();
        for (int c = 0; c < ph_ncyc[p]; c++) begin
            cke     = 1'b1;
            inj_err = inject_at(p, c);
            next_cycle();
        end
        cke     = 1'b0;
        inj_err = 1'b0;
        repeat (IDLE_CYCLES) next_cycle();
        // words still hold the last snapshot
        check_counts(prev_err, prev_total);
        snap = 1'b1;
        next_cycle();
        snap = 1'b0;
        repeat (READ_CYCLES) next_cycle();
        check_counts(ph_err[p], ph_total[p]);
        prev_err   = ph_err[p];
        prev_total = ph_total[p];
    endtask

    ////////////////////////////////
    // main sequence
    ////////////////////////////////

    initial begin
        logic   ok;
        longint cycles;
        cdr_rstb  = 1'b0;
        thresh    = '0;
        inj_err   = 1'b0;
        cke       = 1'b0;
        main_src  = SRC_BIST;
        trig_src  = SRC_BIST;
        chan_sel  = '0;
        sel_count = CHK_MAIN;
        snap      = 1'b0;
        for (int k = 0; k < NTI; k++) begin
            adc_codes[k] = '0;
        end
        load_golden(ok);
        if (!ok) begin
            $display(">>> FAIL");
            $finish;
        end else begin
            cycles = RST_CYCLES;
            foreach (ph_ncyc[p]) begin
                cycles += ph_ncyc[p] + 10;
            end
            watchdog_ns = longint'(CLK_PERIOD) * cycles * 2;
            repeat (RST_CYCLES) @(posedge clk_adc);
            #(DRIVE_DELAY);
            cdr_rstb = 1'b1;
            foreach (ph_ncyc[p]) begin
                run_phase(p);
            end
            $display("checks run: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

//--- verilog.f
hdl/rx_pkg.sv
hdl/prbs_pkg.sv
hdl/adc_slicer.sv
hdl/prbs_bist_gen.sv
hdl/prbs_lane_checker.sv
hdl/prbs_count_readout.sv
hdl/prbs_test_core.sv
tb/tb_prbs_test_core.sv

//--- tb/prbs_golden.txt
# columns: main_src trig_src thresh(hex) code(hex) chan_sel(hex) cke_cycles n_inj inj0..inj3
#          sel_count exp_err exp_total (cumulative counts of the selected checker)
# after reset, both checkers read zero
1 1 00 00 ffff 0 0 0 0 0 0 0 0 0
1 1 00 00 ffff 0 0 0 0 0 0 1 0 0
# first BIST run, warm-up eats 7 cycles
1 1 00 00 ffff 40 0 0 0 0 0 0 0 528
# two injected errors, 3 x 16 each
1 1 00 00 ffff 40 2 5 20 0 0 0 96 1168
# main on ADC, code above threshold, all checked bits fail
0 1 10 20 ffff 30 0 0 0 0 0 0 576 1648
# trigger checker on BIST stays clean
0 1 10 20 ffff 20 0 0 0 0 0 1 96 1968
# code equal to a negative threshold, all zeros
0 1 e0 e0 ffff 20 0 0 0 0 0 0 896 2288
# signed compare, 5 above -16, lower eight lanes only
0 1 f0 05 00ff 25 0 0 0 0 0 0 1096 2488
# lane subset with injections, read trigger
1 1 00 00 0f0f 30 2 8 16 0 0 1 144 2728
1 1 00 00 ffff 16 0 0 0 0 0 0 1144 2984
